// File: source/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// memory depth in 64-bit beats
`define BUS_MEM_WORDS 256

// machine timer low half
`define BUS_RTC_ADDR 32'ha000_0048

// machine timer high half sits one word above
`define BUS_RTC_ADDR_UP (`BUS_RTC_ADDR + 32'd4)

// 1 = random ready stalls in the memory
`define BUS_SRAM_STALL 1

// nonzero start value of the stall lfsr
`define BUS_LFSR_SEED 20'h5a3c1

`endif

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // address, data and strobe widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [3:0]  strb_t;
  typedef logic [7:0]  beat_strb_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [2:0]  axi_prot_t;

  // every response from the memory is okay
  localparam axi_resp_t RESP_OKAY = 2'b00;

  // core side requests and response
  typedef struct packed {addr_t addr;} fetch_req_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } lsu_req_t;

  typedef struct packed {word_t rdata;} bus_rsp_t;

  // axi4-lite channels where aw reuses the ar layout
  typedef struct packed {
    addr_t     addr;
    axi_prot_t prot;
  } axi_ar_t;

  typedef struct packed {
    beat_t      data;
    beat_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    beat_t     data;
    axi_resp_t resp;
  } axi_r_t;

  typedef struct packed {axi_resp_t resp;} axi_b_t;

  // arbiter fsm
  typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_REQ, WR_RESP, TMR_RD} arb_state_e;

endpackage

`default_nettype wire

// File: source/bus_clint.sv
`default_nettype none

module bus_clint (
  input  wire                  clk,
  input  wire                  rst,
  // one-cycle read strobe
  input  wire                  rd_i,
  // 1 selects the upper 32 bits
  input  wire                  hi_i,
  output bus_pkg::word_t       rdata_o
);

  // machine time, counts clock cycles
  logic [63:0] mtime_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q <= '0;
    end
    else
    begin
      // free running and wraps at the top
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // requested half held until the next read
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (hi_i)
        rdata_o <= mtime_q[63:32];
      else
        rdata_o <= mtime_q[31:0];
    end
  end

endmodule

`default_nettype wire

// File: source/bus_sram.sv
`default_nettype none

`include "bus_cfg.svh"

module bus_sram (
  input  wire                      clk,
  input  wire                      rst,
  // read address
  input  wire                      ar_valid_i,
  input  wire bus_pkg::axi_ar_t    ar_i,
  output logic                     ar_ready_o,
  // read data
  output logic                     r_valid_o,
  output bus_pkg::axi_r_t          r_o,
  input  wire                      r_ready_i,
  // write address
  input  wire                      aw_valid_i,
  input  wire bus_pkg::axi_ar_t    aw_i,
  output logic                     aw_ready_o,
  // write data
  input  wire                      w_valid_i,
  input  wire bus_pkg::axi_w_t     w_i,
  output logic                     w_ready_o,
  // write response
  output logic                     b_valid_o,
  output bus_pkg::axi_b_t          b_o,
  input  wire                      b_ready_i
);
  import bus_pkg::*;

  localparam int IDX_W = $clog2(`BUS_MEM_WORDS);

  beat_t             mem_q [`BUS_MEM_WORDS];
  logic [19:0]       lfsr_q;
  logic              go;
  // response pending flags
  logic              r_pend_q;
  logic              b_pend_q;
  beat_t             r_data_q;
  // halves of a write that arrived alone
  logic              aw_have_q;
  logic              w_have_q;
  axi_ar_t           aw_q;
  axi_w_t            w_q;

  logic              ar_fire;
  logic              aw_fire;
  logic              w_fire;
  logic              wr_commit;
  addr_t             wr_addr;
  axi_w_t            wr_data;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;

  // top lfsr bit throttles every ready when stalls are on
  assign go = (`BUS_SRAM_STALL != 0) ? lfsr_q[19] : 1'b1;

  assign ar_ready_o = go && (!r_pend_q || r_ready_i);
  assign aw_ready_o = go && !aw_have_q && (!b_pend_q || b_ready_i);
  assign w_ready_o  = go && !w_have_q && (!b_pend_q || b_ready_i);

  assign ar_fire = ar_valid_i && ar_ready_o;
  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_fire  = w_valid_i && w_ready_o;

  // write goes in once both address and data are here
  assign wr_commit = (aw_fire || aw_have_q) && (w_fire || w_have_q);
  assign wr_addr   = aw_have_q ? aw_q.addr : aw_i.addr;
  assign wr_data   = w_have_q ? w_q : w_i;

  // beat index wraps modulo depth
  assign rd_idx = ar_i.addr[3 +: IDX_W];
  assign wr_idx = wr_addr[3 +: IDX_W];

  assign r_valid_o = r_pend_q;
  assign r_o.data  = r_data_q;
  assign r_o.resp  = RESP_OKAY;
  assign b_valid_o = b_pend_q;
  assign b_o.resp  = RESP_OKAY;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lfsr_q    <= `BUS_LFSR_SEED;
      r_pend_q  <= 1'b0;
      b_pend_q  <= 1'b0;
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
    end
    else
    begin
      // taps 20 and 17
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
      if (ar_fire)
        r_pend_q <= 1'b1;
      else if (r_ready_i)
        r_pend_q <= 1'b0;
      if (wr_commit)
      begin
        b_pend_q  <= 1'b1;
        aw_have_q <= 1'b0;
        w_have_q  <= 1'b0;
      end
      else
      begin
        if (b_ready_i)
          b_pend_q <= 1'b0;
        if (aw_fire)
          aw_have_q <= 1'b1;
        if (w_fire)
          w_have_q <= 1'b1;
      end
    end
  end

  // data path for the array and the held halves
  always_ff @(posedge clk)
  begin
    if (ar_fire)
      r_data_q <= mem_q[rd_idx];
    if (aw_fire)
      aw_q <= aw_i;
    if (w_fire)
      w_q <= w_i;
    if (wr_commit)
    begin
      for (int i = 0; i < 8; i++)
      begin
        // only strobed bytes change
        if (wr_data.strb[i])
          mem_q[wr_idx][8*i +: 8] <= wr_data.data[8*i +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
`default_nettype none

`include "bus_cfg.svh"

module bus_arbiter (
  input  wire                          clk,
  input  wire                          rst,
  // fetch port
  input  wire                          fetch_valid_i,
  input  wire bus_pkg::fetch_req_t     fetch_req_i,
  output logic                         fetch_rvalid_o,
  output bus_pkg::bus_rsp_t            fetch_rsp_o,
  // load/store port
  input  wire                          lsu_valid_i,
  input  wire bus_pkg::lsu_req_t       lsu_req_i,
  output logic                         lsu_done_o,
  output bus_pkg::bus_rsp_t            lsu_rsp_o,
  // axi4-lite master
  output logic                         ar_valid_o,
  output bus_pkg::axi_ar_t             ar_o,
  input  wire                          ar_ready_i,
  input  wire                          r_valid_i,
  input  wire bus_pkg::axi_r_t         r_i,
  output logic                         r_ready_o,
  output logic                         aw_valid_o,
  output bus_pkg::axi_ar_t             aw_o,
  input  wire                          aw_ready_i,
  output logic                         w_valid_o,
  output bus_pkg::axi_w_t              w_o,
  input  wire                          w_ready_i,
  input  wire                          b_valid_i,
  input  wire bus_pkg::axi_b_t         b_i,
  output logic                         b_ready_o,
  // timer
  output logic                         tmr_rd_o,
  output logic                         tmr_hi_o,
  input  wire bus_pkg::word_t          tmr_rdata_i
);
  import bus_pkg::*;

  arb_state_e state_q;
  // winning request with fetches stored as loads
  lsu_req_t   req_q;
  logic       owner_lsu_q;
  // aw and w may transfer on different cycles
  logic       aw_done_q;
  logic       w_done_q;
  word_t      rsp_q;

  logic       lsu_ok;
  logic       fetch_ok;
  logic       lsu_is_tmr;
  lsu_req_t   fetch_as_req;
  logic       aw_fire;
  logic       w_fire;
  logic       wr_sent;
  word_t      r_half;
  word_t      r_aligned;
  strb_t      strb_sh;

  // a port is not taken again in its own response cycle
  assign lsu_ok   = lsu_valid_i && !lsu_done_o;
  assign fetch_ok = fetch_valid_i && !fetch_rvalid_o;

  // timer decode for loads only
  assign lsu_is_tmr = !lsu_req_i.we &&
                      ((lsu_req_i.addr == `BUS_RTC_ADDR) || (lsu_req_i.addr == `BUS_RTC_ADDR_UP));

  always_comb
  begin
    fetch_as_req      = '0;
    fetch_as_req.addr = fetch_req_i.addr;
  end

  // timer strobe leaves straight from idle and data returns one cycle later
  assign tmr_rd_o = (state_q == IDLE) && lsu_ok && lsu_is_tmr;
  assign tmr_hi_o = (lsu_req_i.addr == `BUS_RTC_ADDR_UP);

  // prot[2] on the read address marks instruction fetches
  assign ar_valid_o = (state_q == RD_ADDR);
  assign ar_o.addr  = req_q.addr;
  assign ar_o.prot  = {!owner_lsu_q, 2'b00};
  assign r_ready_o  = 1'b1;

  // write address and data raised together
  assign aw_valid_o = (state_q == WR_REQ) && !aw_done_q;
  assign w_valid_o  = (state_q == WR_REQ) && !w_done_q;
  assign aw_o.addr  = req_q.addr;
  assign aw_o.prot  = 3'b000;
  assign aw_fire    = aw_valid_o && aw_ready_i;
  assign w_fire     = w_valid_o && w_ready_i;
  assign wr_sent    = (aw_done_q || aw_fire) && (w_done_q || w_fire);
  assign b_ready_o  = 1'b1;

  // word copied into both halves and strobe moved to its lane group
  assign strb_sh   = req_q.wstrb << req_q.addr[1:0];
  assign w_o.data  = {req_q.wdata, req_q.wdata};
  assign w_o.strb  = req_q.addr[2] ? {strb_sh, 4'b0000} : {4'b0000, strb_sh};

  // pick half of the beat and then drop the low bytes
  assign r_half    = req_q.addr[2] ? r_i.data[63:32] : r_i.data[31:0];
  assign r_aligned = r_half >> {req_q.addr[1:0], 3'b000};

  // one response register shared by both ports
  assign fetch_rsp_o.rdata = rsp_q;
  assign lsu_rsp_o.rdata   = rsp_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q        <= IDLE;
      owner_lsu_q    <= 1'b0;
      aw_done_q      <= 1'b0;
      w_done_q       <= 1'b0;
      fetch_rvalid_o <= 1'b0;
      lsu_done_o     <= 1'b0;
    end
    else
    begin
      // response pulses last one cycle
      fetch_rvalid_o <= 1'b0;
      lsu_done_o     <= 1'b0;
      case (state_q)
        IDLE:
        begin
          // load/store wins over fetch
          if (lsu_ok)
          begin
            owner_lsu_q <= 1'b1;
            if (lsu_req_i.we)
              state_q <= WR_REQ;
            else if (lsu_is_tmr)
              state_q <= TMR_RD;
            else
              state_q <= RD_ADDR;
          end
          else if (fetch_ok)
          begin
            owner_lsu_q <= 1'b0;
            state_q     <= RD_ADDR;
          end
        end
        RD_ADDR:
          if (ar_ready_i)
            state_q <= RD_DATA;
        RD_DATA:
          if (r_valid_i)
          begin
            state_q        <= IDLE;
            fetch_rvalid_o <= !owner_lsu_q;
            lsu_done_o     <= owner_lsu_q;
          end
        WR_REQ:
          if (wr_sent)
          begin
            state_q   <= WR_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
          else
          begin
            if (aw_fire)
              aw_done_q <= 1'b1;
            if (w_fire)
              w_done_q <= 1'b1;
          end
        WR_RESP:
          if (b_valid_i)
          begin
            state_q    <= IDLE;
            lsu_done_o <= 1'b1;
          end
        TMR_RD:
        begin
          state_q    <= IDLE;
          lsu_done_o <= 1'b1;
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk)
  begin
    if (state_q == IDLE)
    begin
      if (lsu_ok)
        req_q <= lsu_req_i;
      else if (fetch_ok)
        req_q <= fetch_as_req;
    end
    if ((state_q == RD_DATA) && r_valid_i)
      rsp_q <= r_aligned;
    // stores answer with zero
    if ((state_q == WR_RESP) && b_valid_i)
      rsp_q <= '0;
    if (state_q == TMR_RD)
      rsp_q <= tmr_rdata_i;
  end

endmodule

`default_nettype wire

// File: source/bus_top.sv
`default_nettype none

module bus_top (
  input  wire                        clk,
  input  wire                        rst,
  // fetch port
  input  wire                        fetch_valid_i,
  input  wire bus_pkg::fetch_req_t   fetch_req_i,
  output logic                       fetch_rvalid_o,
  output bus_pkg::bus_rsp_t          fetch_rsp_o,
  // load/store port
  input  wire                        lsu_valid_i,
  input  wire bus_pkg::lsu_req_t     lsu_req_i,
  output logic                       lsu_done_o,
  output bus_pkg::bus_rsp_t          lsu_rsp_o
);
  import bus_pkg::*;

  // axi4-lite between arbiter and memory
  logic    ar_valid;
  axi_ar_t ar;
  logic    ar_ready;
  logic    r_valid;
  axi_r_t  r;
  logic    r_ready;
  logic    aw_valid;
  axi_ar_t aw;
  logic    aw_ready;
  logic    w_valid;
  axi_w_t  w;
  logic    w_ready;
  logic    b_valid;
  axi_b_t  b;
  logic    b_ready;

  // timer side
  logic    tmr_rd;
  logic    tmr_hi;
  word_t   tmr_rdata;

  bus_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .fetch_valid_i(fetch_valid_i), .fetch_req_i(fetch_req_i),
    .fetch_rvalid_o(fetch_rvalid_o), .fetch_rsp_o(fetch_rsp_o),
    .lsu_valid_i(lsu_valid_i), .lsu_req_i(lsu_req_i),
    .lsu_done_o(lsu_done_o), .lsu_rsp_o(lsu_rsp_o),
    .ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
    .r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready),
    .aw_valid_o(aw_valid), .aw_o(aw), .aw_ready_i(aw_ready),
    .w_valid_o(w_valid), .w_o(w), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_i(b), .b_ready_o(b_ready),
    .tmr_rd_o(tmr_rd), .tmr_hi_o(tmr_hi), .tmr_rdata_i(tmr_rdata)
  );

  bus_clint u_clint (
    .clk(clk), .rst(rst),
    .rd_i(tmr_rd), .hi_i(tmr_hi), .rdata_o(tmr_rdata)
  );

  // on-chip memory closes the master
  bus_sram u_sram (
    .clk(clk), .rst(rst),
    .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready),
    .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
    .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready)
  );

endmodule

`default_nettype wire

// File: testbench/bus_top_tb.sv
`default_nettype none

`include "bus_cfg.svh"

module bus_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import bus_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int IDX_W           = $clog2(`BUS_MEM_WORDS);
  localparam int WAIT_CYCLES     = 40;
  localparam int TBL_LEN         = 21;
  localparam int RAND_PAIRS      = 12;
  // four accesses per random pair plus reset and idle time
  localparam int WATCHDOG_CYCLES = WAIT_CYCLES * (TBL_LEN + 4 * RAND_PAIRS + 1);

  typedef enum logic [1:0] {PORT_LSU, PORT_FETCH, PORT_BOTH, PORT_RTC} port_e;

  typedef struct packed {
    port_e port;
    logic  we;
    addr_t addr;
    word_t wdata;
    strb_t strb;
  } stim_t;

  logic       clk;
  logic       rst;
  logic       fetch_valid_i;
  fetch_req_t fetch_req_i;
  logic       fetch_rvalid_o;
  bus_rsp_t   fetch_rsp_o;
  logic       lsu_valid_i;
  lsu_req_t   lsu_req_i;
  logic       lsu_done_o;
  bus_rsp_t   lsu_rsp_o;

  // reference copy of the memory beats
  beat_t       ref_mem [`BUS_MEM_WORDS];
  logic [15:0] lfsr_state = 16'd38746;
  word_t       last_lo;
  logic        have_lo;

  // word stores first, so partial stores never touch unwritten bytes
  stim_t stim [TBL_LEN] = '{
    '{PORT_LSU,   1'b1, 32'h8000_0100, 32'h1122_3344, 4'hf},
    '{PORT_LSU,   1'b1, 32'h8000_0104, 32'h5566_7788, 4'hf},
    '{PORT_LSU,   1'b0, 32'h8000_0100, 32'h0,         4'h0},
    '{PORT_LSU,   1'b0, 32'h8000_0104, 32'h0,         4'h0},
    '{PORT_FETCH, 1'b0, 32'h8000_0100, 32'h0,         4'h0},
    '{PORT_FETCH, 1'b0, 32'h8000_0104, 32'h0,         4'h0},
    '{PORT_LSU,   1'b1, 32'h8000_0101, 32'h0000_ab00, 4'h1},
    '{PORT_LSU,   1'b1, 32'h8000_0106, 32'hcdef_0000, 4'h3},
    '{PORT_LSU,   1'b0, 32'h8000_0100, 32'h0,         4'h0},
    '{PORT_LSU,   1'b0, 32'h8000_0101, 32'h0,         4'h0},
    '{PORT_LSU,   1'b0, 32'h8000_0102, 32'h0,         4'h0},
    '{PORT_LSU,   1'b0, 32'h8000_0103, 32'h0,         4'h0},
    '{PORT_LSU,   1'b0, 32'h8000_0106, 32'h0,         4'h0},
    '{PORT_LSU,   1'b1, 32'h8000_0208, 32'hdead_beef, 4'hf},
    '{PORT_BOTH,  1'b1, 32'h8000_0210, 32'h0bad_f00d, 4'hf},
    '{PORT_BOTH,  1'b0, 32'h8000_0208, 32'h0,         4'h0},
    '{PORT_RTC,   1'b0, `BUS_RTC_ADDR, 32'h0,         4'h0},
    '{PORT_RTC,   1'b0, `BUS_RTC_ADDR, 32'h0,         4'h0},
    '{PORT_RTC,   1'b0, `BUS_RTC_ADDR_UP, 32'h0,      4'h0},
    '{PORT_LSU,   1'b0, 32'h8000_0104, 32'h0,         4'h0},
    '{PORT_FETCH, 1'b0, 32'h8000_0210, 32'h0,         4'h0}
  };

  bus_top uut (
    .clk(clk), .rst(rst),
    .fetch_valid_i(fetch_valid_i), .fetch_req_i(fetch_req_i),
    .fetch_rvalid_o(fetch_rvalid_o), .fetch_rsp_o(fetch_rsp_o),
    .lsu_valid_i(lsu_valid_i), .lsu_req_i(lsu_req_i),
    .lsu_done_o(lsu_done_o), .lsu_rsp_o(lsu_rsp_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  initial
  begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
    fail_run();
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_pulse(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      if (got === 1'b1)
        $display("unexpected response pulse on %s", name);
      else
        $display("missing response pulse on %s", name);
      fail_run();
    end
  endtask

  // galois lfsr stepped once per bit
  function automatic word_t take_bits(input int n);
    word_t v;
    logic  lsb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb)
        lfsr_state = lfsr_state ^ 16'hb400;
      v = {v[30:0], lsb};
    end
    return v;
  endfunction

  // strobe moves up by the byte offset and bit 2 picks the half
  task automatic model_store(input addr_t a, input word_t wd, input strb_t s);
    strb_t lanes;
    int    base;
    lanes = s << a[1:0];
    base  = a[2] ? 32 : 0;
    for (int i = 0; i < 4; i++)
    begin
      if (lanes[i])
        ref_mem[a[3 +: IDX_W]][base + 8*i +: 8] = wd[8*i +: 8];
    end
  endtask

  function automatic word_t model_load(input addr_t a);
    word_t w;
    w = a[2] ? ref_mem[a[3 +: IDX_W]][63:32] : ref_mem[a[3 +: IDX_W]][31:0];
    return w >> {a[1:0], 3'b000};
  endfunction

  // raise the requested valids and wait for every pulse
  task automatic run_access(input logic do_lsu, input logic do_fetch, input lsu_req_t lreq,
                            input fetch_req_t freq, output word_t lsu_rd, output word_t fetch_rd);
    logic lsu_seen;
    logic fetch_seen;
    int   n;
    lsu_seen      = 1'b0;
    fetch_seen    = 1'b0;
    n             = 0;
    lsu_rd        = '0;
    fetch_rd      = '0;
    lsu_req_i     = lreq;
    fetch_req_i   = freq;
    lsu_valid_i   = do_lsu;
    fetch_valid_i = do_fetch;
    while (((do_lsu && !lsu_seen) || (do_fetch && !fetch_seen)) && (n < 2 * WAIT_CYCLES))
    begin
      @(posedge clk);
      #1;
      n++;
      if (lsu_done_o)
      begin
        if (!do_lsu || lsu_seen)
          check_pulse("lsu_done_o", 1'b1, 1'b0);
        lsu_seen    = 1'b1;
        lsu_rd      = lsu_rsp_o.rdata;
        lsu_valid_i = 1'b0;
      end
      if (fetch_rvalid_o)
      begin
        if (!do_fetch || fetch_seen)
          check_pulse("fetch_rvalid_o", 1'b1, 1'b0);
        // load/store has priority
        if (do_lsu && !lsu_seen)
        begin
          $display("fetch was answered before the pending load/store");
          fail_run();
        end
        fetch_seen    = 1'b1;
        fetch_rd      = fetch_rsp_o.rdata;
        fetch_valid_i = 1'b0;
      end
    end
    check_pulse("lsu_done_o", lsu_seen, do_lsu);
    check_pulse("fetch_rvalid_o", fetch_seen, do_fetch);
    lsu_req_i   = '0;
    fetch_req_i = '0;
    // pulses last one cycle only
    @(posedge clk);
    #1;
    check_pulse("lsu_done_o", lsu_done_o, 1'b0);
    check_pulse("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
  endtask

  task automatic apply_entry(input stim_t e);
    lsu_req_t   lreq;
    fetch_req_t freq;
    word_t      lrd;
    word_t      frd;
    lreq.we    = e.we;
    lreq.addr  = e.addr;
    lreq.wdata = e.wdata;
    lreq.wstrb = e.strb;
    freq.addr  = e.addr;
    case (e.port)
      PORT_LSU:
      begin
        run_access(1'b1, 1'b0, lreq, freq, lrd, frd);
        if (e.we)
        begin
          check_word("lsu_rsp_o", lrd, '0);
          model_store(e.addr, e.wdata, e.strb);
        end
        else
          check_word("lsu_rsp_o", lrd, model_load(e.addr));
      end
      PORT_FETCH:
      begin
        run_access(1'b0, 1'b1, lreq, freq, lrd, frd);
        check_word("fetch_rsp_o", frd, model_load(e.addr));
      end
      PORT_BOTH:
      begin
        run_access(1'b1, 1'b1, lreq, freq, lrd, frd);
        // fetch runs after the store, so it sees the new data
        if (e.we)
        begin
          check_word("lsu_rsp_o", lrd, '0);
          model_store(e.addr, e.wdata, e.strb);
        end
        else
          check_word("lsu_rsp_o", lrd, model_load(e.addr));
        check_word("fetch_rsp_o", frd, model_load(e.addr));
      end
      default:
      begin
        run_access(1'b1, 1'b0, lreq, freq, lrd, frd);
        // high half stays zero this early
        if (e.addr == `BUS_RTC_ADDR_UP)
          check_word("lsu_rsp_o", lrd, '0);
        else
        begin
          if (have_lo && !(lrd > last_lo))
          begin
            $display("timer low half did not increase, 0x%08h after 0x%08h", lrd, last_lo);
            fail_run();
          end
          last_lo = lrd;
          have_lo = 1'b1;
        end
      end
    endcase
  endtask

  initial
  begin
    addr_t base;
    word_t wd;
    word_t rnd;
    word_t off;
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_req_i   = '0;
    lsu_valid_i   = 1'b0;
    lsu_req_i     = '0;
    have_lo       = 1'b0;
    last_lo       = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    // quiet bus after reset
    repeat (10)
    begin
      @(posedge clk);
      #1;
      check_pulse("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
      check_pulse("lsu_done_o", lsu_done_o, 1'b0);
    end
    for (int i = 0; i < TBL_LEN; i++)
      apply_entry(stim[i]);
    // random word, random partial store, load at random offset, fetch
    for (int p = 0; p < RAND_PAIRS; p++)
    begin
      base = 32'h8000_0000 | (take_bits(9) << 2);
      wd   = take_bits(32);
      rnd  = take_bits(4);
      off  = take_bits(2);
      apply_entry(stim_t'{PORT_LSU, 1'b1, base, wd, 4'hf});
      // partial strobe stays inside its word
      apply_entry(stim_t'{PORT_LSU, 1'b1, base | off, ~wd, rnd[3:0] & (4'hf >> off[1:0])});
      apply_entry(stim_t'{PORT_LSU, 1'b0, base | take_bits(2), 32'h0, 4'h0});
      apply_entry(stim_t'{PORT_FETCH, 1'b0, base, 32'h0, 4'h0});
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/bus_pkg.sv
source/bus_clint.sv
source/bus_sram.sv
source/bus_arbiter.sv
source/bus_top.sv
testbench/bus_top_tb.sv

// File: run.sh
#!/bin/sh
# build and run the bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module bus_top_tb \
  --Mdir obj_dir -o bus_top_tb_sim

# a failing run is judged by the log below
./obj_dir/bus_top_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
